/* design/rvPkg.sv */
package rvPkg;

    localparam int XLEN      = 32;
    localparam int REG_COUNT = 32;

    typedef logic [XLEN-1:0] wordT;
    typedef logic [4:0]      regAddrT;
    typedef logic [3:0]      aluOpT;

    localparam aluOpT ALU_AND = 4'd0;
    localparam aluOpT ALU_OR  = 4'd1;
    localparam aluOpT ALU_ADD = 4'd2;
    localparam aluOpT ALU_SLL = 4'd3;
    localparam aluOpT ALU_SRL = 4'd4;
    localparam aluOpT ALU_SRA = 4'd5;
    localparam aluOpT ALU_SUB = 4'd6;
    localparam aluOpT ALU_SLT = 4'd7;
    localparam aluOpT ALU_XOR = 4'd8;

    localparam logic [6:0] OPC_RTYPE = 7'b0110011;
    localparam logic [6:0] OPC_ITYPE = 7'b0010011;
    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;

    localparam wordT NOP_INSTR = 32'h0000_0013; // addi x0, x0, 0

    typedef struct packed {
        logic regWrite;
        logic memToReg;
        logic memRead;
        logic memWrite;
        logic aluSrc;                 // operand b from imm
    } ctrlT;

    typedef struct packed {
        logic valid;
        wordT pc;
        wordT instr;
    } ifIdT;

    typedef struct packed {
        ctrlT       ctrl;
        wordT       rs1Data;
        wordT       rs2Data;
        wordT       imm;
        regAddrT    rs1;
        regAddrT    rs2;
        regAddrT    rd;
        logic [2:0] funct3;
        logic       funct7b5;
    } idExT;

    typedef struct packed {
        ctrlT    ctrl;
        wordT    aluOut;
        wordT    storeData;
        regAddrT rd;
    } exMemT;

    typedef struct packed {
        logic    regWrite;
        logic    memToReg;
        wordT    loadData;
        wordT    aluOut;
        regAddrT rd;
    } memWbT;

endpackage

/* design/fetchStage.sv */
`timescale 1ns/1ps

module fetchStage (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        icacheStall,
    input  logic        dcacheStall,
    input  logic        loadUseStall,
    input  rvPkg::wordT icacheRdata,
    output logic        icacheRen,
    output rvPkg::wordT icacheAddr,
    output rvPkg::ifIdT ifId
);
    import rvPkg::*;

    wordT pc;
    logic holdIfId;

    assign holdIfId   = dcacheStall || loadUseStall;
    assign icacheAddr = pc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc        <= '0;
            icacheRen <= 1'b0;
            ifId      <= '0;
        end else begin
            icacheRen <= 1'b1;
            if (!holdIfId && !icacheStall) begin
                pc <= pc + XLEN'(4);   // no branches, always sequential
            end
            if (!holdIfId) begin
                if (icacheStall) begin
                    ifId <= '{valid: 1'b0, pc: pc, instr: NOP_INSTR}; // bubble
                end else begin
                    ifId <= '{valid: 1'b1, pc: pc, instr: icacheRdata};
                end
            end
        end
    end

    pcAligned: assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00)
        else $error("pc not word aligned: %h", pc);

endmodule

/* design/regFile.sv */
`timescale 1ns/1ps

module regFile (
    input  logic           clk,
    input  logic           rst_n,
    input  rvPkg::regAddrT rs1,
    input  rvPkg::regAddrT rs2,
    output rvPkg::wordT    rs1Data,
    output rvPkg::wordT    rs2Data,
    input  logic           we,
    input  rvPkg::regAddrT rd,
    input  rvPkg::wordT    wdata
);
    import rvPkg::*;

    wordT regs [REG_COUNT];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;        // x0 never written
        end
    end

    // same-cycle write is passed straight to the read ports
    assign rs1Data = (rs1 == '0) ? '0 : (we && rd == rs1) ? wdata : regs[rs1];
    assign rs2Data = (rs2 == '0) ? '0 : (we && rd == rs2) ? wdata : regs[rs2];

    x0ReadsZero: assert property (@(posedge clk) disable iff (!rst_n)
        (rs1 != '0 || rs1Data == '0) && (rs2 != '0 || rs2Data == '0))
        else $error("x0 read nonzero: rs1Data=%h rs2Data=%h", rs1Data, rs2Data);

endmodule

/* design/decodeStage.sv */
`timescale 1ns/1ps

module decodeStage (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           dcacheStall,
    input  rvPkg::ifIdT    ifId,
    output rvPkg::regAddrT rs1,
    output rvPkg::regAddrT rs2,
    input  rvPkg::wordT    rs1Data,
    input  rvPkg::wordT    rs2Data,
    output logic           loadUseStall,
    output rvPkg::idExT    idEx
);
    import rvPkg::*;

    logic [6:0] opcode;
    regAddrT    rd;
    ctrlT       ctrl;
    wordT       imm;
    logic       usesRs1;
    logic       usesRs2;
    idExT       idExNext;

    assign opcode = ifId.instr[6:0];
    assign rs1    = ifId.instr[19:15];
    assign rs2    = ifId.instr[24:20];
    assign rd     = ifId.instr[11:7];

    always_comb begin
        ctrl = '0;                    // unknown opcode acts as nop
        if (ifId.valid) begin
            case (opcode)
                OPC_RTYPE: begin
                    ctrl.regWrite = 1'b1;
                end
                OPC_ITYPE: begin
                    ctrl.regWrite = 1'b1;
                    ctrl.aluSrc   = 1'b1;
                end
                OPC_LOAD: begin
                    ctrl.regWrite = 1'b1;
                    ctrl.memToReg = 1'b1;
                    ctrl.memRead  = 1'b1;
                    ctrl.aluSrc   = 1'b1;
                end
                OPC_STORE: begin
                    ctrl.memWrite = 1'b1;
                    ctrl.aluSrc   = 1'b1;
                end
                default: begin
                end
            endcase
        end
    end

    always_comb begin
        if (opcode == OPC_STORE) begin
            imm = {{20{ifId.instr[31]}}, ifId.instr[31:25], ifId.instr[11:7]};
        end else begin
            imm = {{20{ifId.instr[31]}}, ifId.instr[31:20]}; // sign-extended I imm
        end
    end

    // only real source operands can cause a load-use hazard
    assign usesRs1 = ctrl.regWrite || ctrl.memWrite;
    assign usesRs2 = ctrl.memWrite || (ctrl.regWrite && !ctrl.aluSrc);

    assign loadUseStall = idEx.ctrl.memRead && (idEx.rd != '0)
                          && ((usesRs1 && idEx.rd == rs1) || (usesRs2 && idEx.rd == rs2));

    always_comb begin
        idExNext.ctrl     = loadUseStall ? '0 : ctrl;
        idExNext.rs1Data  = rs1Data;
        idExNext.rs2Data  = rs2Data;
        idExNext.imm      = imm;
        idExNext.rs1      = rs1;
        idExNext.rs2      = rs2;
        idExNext.rd       = rd;
        idExNext.funct3   = ifId.instr[14:12];
        idExNext.funct7b5 = ifId.instr[30];
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            idEx <= '0;
        end else if (!dcacheStall) begin
            idEx <= idExNext;
        end
    end

    noRdWrConflict: assert property (@(posedge clk) disable iff (!rst_n)
        !(idEx.ctrl.memRead && idEx.ctrl.memWrite))
        else $error("idEx holds memRead and memWrite together");

endmodule

/* design/executeStage.sv */
`timescale 1ns/1ps

module executeStage (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           dcacheStall,
    input  rvPkg::idExT    idEx,
    input  logic           wbWe,
    input  rvPkg::regAddrT wbRd,
    input  rvPkg::wordT    wbData,
    output rvPkg::exMemT   exMem
);
    import rvPkg::*;

    wordT  opA;
    wordT  opB;
    wordT  aluB;
    wordT  aluOut;
    aluOpT aluOp;
    logic  holdValid;
    wordT  heldA;
    wordT  heldB;

    // newest producer first, then operands captured during a dcache stall
    function automatic wordT pickOperand(input regAddrT rs, input wordT regData,
                                         input exMemT memEntry, input logic wbOn,
                                         input regAddrT wbDst, input wordT wbVal,
                                         input logic useHeld, input wordT held);
        if (memEntry.ctrl.regWrite && memEntry.rd != '0 && memEntry.rd == rs) begin
            return memEntry.aluOut;
        end
        if (wbOn && wbDst != '0 && wbDst == rs) begin
            return wbVal;
        end
        if (useHeld) begin
            return held;
        end
        return regData;
    endfunction

    assign opA = pickOperand(idEx.rs1, idEx.rs1Data, exMem, wbWe, wbRd, wbData,
                             holdValid, heldA);
    assign opB = pickOperand(idEx.rs2, idEx.rs2Data, exMem, wbWe, wbRd, wbData,
                             holdValid, heldB);

    // writeback entry is dropped while stalled, so keep what it forwarded
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            holdValid <= 1'b0;
        end else begin
            holdValid <= dcacheStall;
        end
    end

    always_ff @(posedge clk) begin
        if (dcacheStall) begin
            heldA <= opA;
            heldB <= opB;
        end
    end

    always_comb begin
        aluOp = ALU_ADD;              // loads and stores add the offset
        if (idEx.ctrl.regWrite && !idEx.ctrl.memToReg) begin
            case (idEx.funct3)
                3'b000:  aluOp = (!idEx.ctrl.aluSrc && idEx.funct7b5) ? ALU_SUB : ALU_ADD;
                3'b001:  aluOp = ALU_SLL;
                3'b010:  aluOp = ALU_SLT;
                3'b100:  aluOp = ALU_XOR;
                3'b101:  aluOp = idEx.funct7b5 ? ALU_SRA : ALU_SRL;
                3'b110:  aluOp = ALU_OR;
                3'b111:  aluOp = ALU_AND;
                default: aluOp = ALU_ADD;
            endcase
        end
    end

    assign aluB = idEx.ctrl.aluSrc ? idEx.imm : opB;

    always_comb begin
        case (aluOp)
            ALU_AND: aluOut = opA & aluB;
            ALU_OR:  aluOut = opA | aluB;
            ALU_ADD: aluOut = opA + aluB;
            ALU_SUB: aluOut = opA - aluB;
            ALU_XOR: aluOut = opA ^ aluB;
            ALU_SLL: aluOut = opA << aluB[4:0];
            ALU_SRL: aluOut = opA >> aluB[4:0];
            ALU_SRA: aluOut = wordT'($signed(opA) >>> aluB[4:0]);
            ALU_SLT: aluOut = {{(XLEN-1){1'b0}}, ($signed(opA) < $signed(aluB))};
            default: aluOut = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            exMem <= '0;
        end else if (!dcacheStall) begin
            exMem <= '{ctrl: idEx.ctrl, aluOut: aluOut, storeData: opB, rd: idEx.rd};
        end
    end

endmodule

/* design/memoryStage.sv */
`timescale 1ns/1ps

module memoryStage (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           dcacheStall,
    input  rvPkg::exMemT   exMem,
    output logic           dcacheRen,
    output logic           dcacheWen,
    output rvPkg::wordT    dcacheAddr,
    output rvPkg::wordT    dcacheWdata,
    input  rvPkg::wordT    dcacheRdata,
    output logic           wbWe,
    output rvPkg::regAddrT wbRd,
    output rvPkg::wordT    wbData
);
    import rvPkg::*;

    memWbT memWb;

    assign dcacheRen   = exMem.ctrl.memRead;
    assign dcacheWen   = exMem.ctrl.memWrite;
    assign dcacheAddr  = exMem.aluOut;
    assign dcacheWdata = exMem.storeData;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            memWb <= '0;
        end else begin
            memWb <= '{regWrite: exMem.ctrl.regWrite && !dcacheStall, // bubble while stalled
                       memToReg: exMem.ctrl.memToReg,
                       loadData: dcacheRdata,
                       aluOut:   exMem.aluOut,
                       rd:       exMem.rd};
        end
    end

    assign wbWe   = memWb.regWrite;
    assign wbRd   = memWb.rd;
    assign wbData = memWb.memToReg ? memWb.loadData : memWb.aluOut;

    strobesExclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(dcacheRen && dcacheWen))
        else $error("dcache ren and wen high together at %h", dcacheAddr);

endmodule

/* design/rvCore.sv */
`timescale 1ns/1ps

module rvCore (
    input  logic        clk,
    input  logic        rst_n,
    output logic        icacheRen,
    output rvPkg::wordT icacheAddr,
    input  rvPkg::wordT icacheRdata,
    input  logic        icacheStall,
    output logic        dcacheRen,
    output logic        dcacheWen,
    output rvPkg::wordT dcacheAddr,
    output rvPkg::wordT dcacheWdata,
    input  rvPkg::wordT dcacheRdata,
    input  logic        dcacheStall
);
    import rvPkg::*;

    ifIdT    ifId;
    idExT    idEx;
    exMemT   exMem;
    regAddrT rs1;
    regAddrT rs2;
    wordT    rs1Data;
    wordT    rs2Data;
    logic    loadUseStall;
    logic    wbWe;
    regAddrT wbRd;
    wordT    wbData;

    fetchStage uFetch (
        .clk, .rst_n, .icacheStall, .dcacheStall, .loadUseStall,
        .icacheRdata, .icacheRen, .icacheAddr, .ifId
    );

    decodeStage uDecode (
        .clk, .rst_n, .dcacheStall, .ifId, .rs1, .rs2,
        .rs1Data, .rs2Data, .loadUseStall, .idEx
    );

    regFile uRegFile (
        .clk, .rst_n, .rs1, .rs2, .rs1Data, .rs2Data,
        .we(wbWe), .rd(wbRd), .wdata(wbData)
    );

    executeStage uExecute (
        .clk, .rst_n, .dcacheStall, .idEx, .wbWe, .wbRd, .wbData, .exMem
    );

    memoryStage uMemory (
        .clk, .rst_n, .dcacheStall, .exMem, .dcacheRen, .dcacheWen,
        .dcacheAddr, .dcacheWdata, .dcacheRdata, .wbWe, .wbRd, .wbData
    );

endmodule

/* dv/rvIsaModel.svh */
`ifndef RV_ISA_MODEL_SVH
`define RV_ISA_MODEL_SVH

wordT prog [64];
int   progLen;
wordT expAddr [64];
wordT expData [64];
int   expCount;
wordT initMem [256];

function automatic wordT encR(input logic [6:0] f7, input int rs2, input int rs1,
                              input logic [2:0] f3, input int rd);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), OPC_RTYPE};
endfunction

function automatic wordT encI(input int imm, input int rs1, input logic [2:0] f3,
                              input int rd, input logic [6:0] opc);
    return {12'(imm), 5'(rs1), f3, 5'(rd), opc};
endfunction

function automatic wordT encS(input int imm, input int rs2, input int rs1);
    logic [11:0] i12;
    i12 = 12'(imm);
    return {i12[11:5], 5'(rs2), 5'(rs1), 3'b010, i12[4:0], OPC_STORE};
endfunction

task automatic addInstr(input wordT w);
    prog[progLen] = w;
    progLen++;
endtask

task automatic buildProgram();
    progLen = 0;
    addInstr(encI(0, 0, 3'b010, 1, OPC_LOAD));     // lw x1, 0(x0)
    addInstr(encI(5, 1, 3'b000, 2, OPC_ITYPE));    // load-use on x1
    addInstr(encS(64, 2, 0));
    addInstr(encI(-7, 0, 3'b000, 3, OPC_ITYPE));
    addInstr(encI(100, 3, 3'b000, 4, OPC_ITYPE));
    addInstr(encR(7'h00, 4, 3, 3'b000, 5));        // add, both operands forwarded
    addInstr(encR(7'h20, 1, 5, 3'b000, 6));        // sub
    addInstr(encR(7'h00, 2, 6, 3'b100, 7));
    addInstr(encR(7'h00, 1, 7, 3'b111, 8));
    addInstr(encR(7'h00, 3, 8, 3'b110, 9));
    addInstr(encR(7'h00, 4, 3, 3'b010, 10));       // slt
    addInstr(encR(7'h00, 4, 7, 3'b001, 11));       // sll by low five bits
    addInstr(encR(7'h00, 10, 3, 3'b101, 12));
    addInstr(encR(7'h20, 10, 3, 3'b101, 13));      // sra
    addInstr(encI(-1, 3, 3'b010, 14, OPC_ITYPE));
    addInstr(encI('h55, 5, 3'b100, 15, OPC_ITYPE));
    addInstr(encI('h7f0, 1, 3'b111, 16, OPC_ITYPE));
    addInstr(encI(-256, 16, 3'b110, 17, OPC_ITYPE));
    addInstr(encI(3, 1, 3'b001, 18, OPC_ITYPE));
    addInstr(encI(4, 3, 3'b101, 19, OPC_ITYPE));
    addInstr(encI('h402, 3, 3'b101, 20, OPC_ITYPE)); // srai by 2
    addInstr(encI(9, 1, 3'b000, 0, OPC_ITYPE));    // write to x0
    addInstr(encS(220, 0, 0));                     // x0 stored right behind its write
    addInstr(encI(4, 0, 3'b010, 21, OPC_LOAD));
    addInstr(encS(128, 21, 0));                    // store right after its load
    for (int r = 3; r <= 20; r++) begin
        addInstr(encS(132 + 4 * (r - 3), r, 0));
    end
endtask

// in-order reference, one instruction at a time
task automatic runModel();
    wordT       regs [32];
    wordT       mem [256];
    wordT       ins;
    wordT       a;
    wordT       b;
    wordT       res;
    wordT       imm;
    logic [6:0] opc;
    for (int i = 0; i < 32; i++) begin
        regs[i] = '0;
    end
    for (int i = 0; i < 256; i++) begin
        mem[i] = initMem[i];
    end
    expCount = 0;
    for (int n = 0; n < progLen; n++) begin
        ins = prog[n];
        opc = ins[6:0];
        a   = regs[ins[19:15]];
        b   = regs[ins[24:20]];
        imm = {{20{ins[31]}}, ins[31:20]};
        res = '0;
        if (opc == OPC_STORE) begin
            imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            res = a + imm;
            expAddr[expCount] = res;
            expData[expCount] = b;
            expCount++;
            mem[res[9:2]] = b;
        end else if (opc == OPC_LOAD) begin
            res = a + imm;
            if (ins[11:7] != 0) begin
                regs[ins[11:7]] = mem[res[9:2]];
            end
        end else if (opc == OPC_RTYPE || opc == OPC_ITYPE) begin
            if (opc == OPC_ITYPE) begin
                b = imm;
            end
            case (ins[14:12])
                3'b000: res = (opc == OPC_RTYPE && ins[30]) ? a - b : a + b;
                3'b001: res = a << b[4:0];
                3'b010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                3'b100: res = a ^ b;
                3'b101: res = ins[30] ? wordT'($signed(a) >>> b[4:0]) : a >> b[4:0];
                3'b110: res = a | b;
                default: res = a & b;
            endcase
            if (ins[11:7] != 0) begin
                regs[ins[11:7]] = res;
            end
        end
    end
endtask

`endif

/* dv/rvCoreTb.sv */
`timescale 1ns/1ps

module rvCoreTb;
    import rvPkg::*;

    `include "rvIsaModel.svh"

    localparam int  PHASES    = 4;
    localparam time MARGIN_NS = 1000ns;

    logic    clk;
    logic    rst_n;
    logic    icacheRen;
    logic    icacheStall;
    logic    dcacheRen;
    logic    dcacheWen;
    logic    dcacheStall;
    wordT    icacheAddr;
    wordT    icacheRdata;
    wordT    dcacheAddr;
    wordT    dcacheWdata;
    wordT    dcacheRdata;
    wordT    dmem [256];
    integer  seed;
    logic    stallOn;
    int      errors;
    int      storeIdx;
    wordT    expAddrNow;
    wordT    expDataNow;
    logic    sIfValid;       // shadow of the fetch/decode register
    wordT    sIfInstr;
    logic    sIdLoad;
    regAddrT sIdRd;
    logic    loadUse;
    logic    advance;

    rvCore u_dut (
        .clk, .rst_n, .icacheRen, .icacheAddr, .icacheRdata, .icacheStall,
        .dcacheRen, .dcacheWen, .dcacheAddr, .dcacheWdata, .dcacheRdata, .dcacheStall
    );

    function automatic logic loadUseHazard(input logic ldValid, input regAddrT ldRd,
                                           input logic v, input wordT ins);
        logic [6:0] opc;
        logic       r1;
        logic       r2;
        opc = ins[6:0];
        r1  = opc == OPC_RTYPE || opc == OPC_ITYPE || opc == OPC_LOAD || opc == OPC_STORE;
        r2  = opc == OPC_RTYPE || opc == OPC_STORE;
        return ldValid && v && ldRd != '0
               && ((r1 && ins[19:15] == ldRd) || (r2 && ins[24:20] == ldRd));
    endfunction

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    assign icacheRdata = (icacheAddr[31:2] < progLen) ? prog[icacheAddr[7:2]] : NOP_INSTR;
    assign dcacheRdata = dmem[dcacheAddr[9:2]];
    assign expAddrNow  = (storeIdx < expCount) ? expAddr[storeIdx] : '0;
    assign expDataNow  = (storeIdx < expCount) ? expData[storeIdx] : '0;
    assign loadUse     = loadUseHazard(sIdLoad, sIdRd, sIfValid, sIfInstr);
    assign advance     = !icacheStall && !dcacheStall && !loadUse;

    always @(posedge clk) begin
        if (dcacheWen && !dcacheStall) begin
            dmem[dcacheAddr[9:2]] <= dcacheWdata;
        end
        if (!rst_n) begin
            storeIdx <= 0;
        end else if (dcacheWen && !dcacheStall) begin
            storeIdx <= storeIdx + 1;
        end
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            sIfValid <= 1'b0;
            sIfInstr <= '0;
            sIdLoad  <= 1'b0;
            sIdRd    <= '0;
        end else if (!dcacheStall) begin
            sIdLoad <= !loadUse && sIfValid && sIfInstr[6:0] == OPC_LOAD;
            sIdRd   <= sIfInstr[11:7];
            if (!loadUse) begin
                sIfValid <= !icacheStall;
                sIfInstr <= icacheRdata;
            end
        end
    end

    // about one cycle in five stalls each cache
    always @(posedge clk) begin
        icacheStall <= stallOn && ($unsigned($random(seed)) % 5 == 0);
        dcacheStall <= stallOn && ($unsigned($random(seed)) % 5 == 0);
    end

    resetAddr: assert property (@(posedge clk) $rose(rst_n) |-> icacheAddr == '0)
        else begin
            errors++;
            $display("Error: icacheAddr %h expected 0 after reset", $sampled(icacheAddr));
        end
    fetchEnable: assert property (@(posedge clk) $past(rst_n) |-> icacheRen)
        else begin
            errors++;
            $display("Error: icacheRen %h expected 1", $sampled(icacheRen));
        end
    fetchEnableReset: assert property (@(posedge clk) $past(!rst_n) |-> !icacheRen)
        else begin
            errors++;
            $display("Error: icacheRen %h expected 0", $sampled(icacheRen));
        end
    fetchStep: assert property (@(posedge clk) disable iff (!rst_n)
        advance |=> icacheAddr == $past(icacheAddr) + 32'd4)
        else begin
            errors++;
            $display("Error: icacheAddr %h expected %h",
                $sampled(icacheAddr), $past(icacheAddr) + 32'd4);
        end
    fetchHold: assert property (@(posedge clk) disable iff (!rst_n)
        !advance |=> $stable(icacheAddr))
        else begin
            errors++;
            $display("Error: icacheAddr %h expected %h",
                $sampled(icacheAddr), $past(icacheAddr));
        end
    storeAddr: assert property (@(posedge clk) disable iff (!rst_n)
        (dcacheWen && !dcacheStall) |-> dcacheAddr == expAddrNow)
        else begin
            errors++;
            $display("Error: dcacheAddr %h expected %h",
                $sampled(dcacheAddr), $sampled(expAddrNow));
        end
    storeData: assert property (@(posedge clk) disable iff (!rst_n)
        (dcacheWen && !dcacheStall) |-> dcacheWdata == expDataNow)
        else begin
            errors++;
            $display("Error: dcacheWdata %h expected %h",
                $sampled(dcacheWdata), $sampled(expDataNow));
        end
    noExtraStore: assert property (@(posedge clk) disable iff (!rst_n)
        (dcacheWen && !dcacheStall) |-> storeIdx < expCount)
        else begin
            errors++;
            $display("more stores completed than the program holds");
        end
    dcacheHold: assert property (@(posedge clk) disable iff (!rst_n)
        dcacheStall |=> $stable(dcacheAddr) && $stable(dcacheWdata)
                        && $stable(dcacheRen) && $stable(dcacheWen))
        else begin
            errors++;
            $display("Error: dcacheAddr %h dcacheWdata %h expected %h %h during stall",
                $sampled(dcacheAddr), $sampled(dcacheWdata),
                $past(dcacheAddr), $past(dcacheWdata));
        end
    strobesInReset: assert property (@(posedge clk) $past(!rst_n) |-> !dcacheRen && !dcacheWen)
        else begin
            errors++;
            $display("data cache strobe high during or right after reset");
        end
    strobesApart: assert property (@(posedge clk) !(dcacheRen && dcacheWen))
        else begin
            errors++;
            $display("dcacheRen and dcacheWen high together");
        end

    task automatic runPhase(input logic withStalls);
        @(posedge clk);
        rst_n   <= 1'b0;
        stallOn <= 1'b0;
        for (int i = 0; i < 256; i++) begin
            dmem[i] <= initMem[i];
        end
        repeat (3) @(posedge clk);
        rst_n   <= 1'b1;
        stallOn <= withStalls;
        wait (storeIdx == expCount);
        repeat (6) @(posedge clk);
        storeCount: assert (storeIdx == expCount)
            else begin
                errors++;
                $display("Error: store count %h expected %h", storeIdx, expCount);
            end
    endtask

    initial begin
        #1;
        #(progLen * 4 * 4 * PHASES * 1ns + MARGIN_NS);
        $display("watchdog expired before the program finished");
        $display("TB FAILED");
        $finish;
    end

    initial begin
        rst_n       <= 1'b0;
        icacheStall <= 1'b0;
        dcacheStall <= 1'b0;
        stallOn     <= 1'b0;
        errors      = 0;
        seed        = 32'h4cb034ee;
        buildProgram();
        for (int i = 0; i < 256; i++) begin
            initMem[i] = $random(seed);
        end
        runModel();
        for (int p = 0; p < PHASES; p++) begin
            runPhase(p >= 2);                   // last two phases stall
        end
        $display("errors %0d, stores per phase %0d", errors, expCount);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+dv
design/rvPkg.sv
design/fetchStage.sv
design/regFile.sv
design/decodeStage.sv
design/executeStage.sv
design/memoryStage.sv
design/rvCore.sv
dv/rvCoreTb.sv

/* run.sh */
#!/bin/sh
# build and run the simulation, result decided from the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module rvCoreTb \
    -o rvCoreSim || exit 1
./obj_dir/rvCoreSim | tee sim.log
grep -q "TB FAILED" sim.log && exit 1
grep -q "TB PASSED" sim.log || exit 1
exit 0
